//--- compile.f
+incdir+include
verilog/core_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/register_file.sv
verilog/ex_stage.sv
verilog/core_top.sv
verif/core_props.sv
verif/core_tb.sv

//--- Makefile
# Verilator flow for the RV32I subset core

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- include/core_tb_cfg.svh
`ifndef CORE_TB_CFG_SVH
`define CORE_TB_CFG_SVH

// Testbench timing
`define TB_CLK_PERIOD  40
`define TB_RST_CYCLES  4
`define TB_SEED        32'h55010b80

`endif

//--- verif/core_tb.sv
`timescale 1ns/1ns
`include "core_cfg.svh"
`include "core_tb_cfg.svh"

module core_tb;

  import core_pkg::*;

  localparam logic [`XLEN-1:0] BOOT_ADDR = 32'h0000_1000;
  localparam int IMEM_WORDS  = 64;
  localparam int TAIL_CYCLES = 20;
  // Grant delay of the first chain store, long enough to fill ID/EX, IF/ID and skid
  localparam int CHAIN_HOLD  = 32;
  // Boot program, then ALU, chain and branch programs, each run twice
  localparam int NUM_INSTR   = 1 + 2 * (24 + 13 + 18);

  logic             clk_i;
  logic             rst_n_i;
  logic [`XLEN-1:0] boot_addr_i;
  logic             instr_req_o;
  logic [`XLEN-1:0] instr_addr_o;
  logic             instr_gnt_i;
  logic             instr_rvalid_i;
  logic [31:0]      instr_rdata_i;
  logic             data_req_o;
  store_req_t       data_o;
  logic             data_gnt_i;

  logic [31:0]      imem [IMEM_WORDS];
  int               prog_len;
  int               max_dly;
  int               first_st_dly;
  int               errors;
  store_req_t       exp_q [$];
  store_req_t       log_q [$];

  initial begin
    clk_i = 1'b0;
    forever #(`TB_CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  core_top i_dut (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_o         ( data_o         ),
    .data_gnt_i     ( data_gnt_i     )
  );

  bind core_top core_props i_props (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .instr_req_o  ( instr_req_o  ),
    .instr_addr_o ( instr_addr_o ),
    .instr_gnt_i  ( instr_gnt_i  ),
    .data_req_o   ( data_req_o   ),
    .data_o       ( data_o       ),
    .data_gnt_i   ( data_gnt_i   )
  );

  //////////////////////////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {imm, rs1, f3, rd, `OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2,
                                         logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1,
                                         logic [4:0] rs2, int off);
    logic [12:0] b;
    b = off[12:0];
    return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, int imm);
    return i_type(imm[11:0], rs1, `F3_ADD_SUB, rd);
  endfunction

  function automatic logic [31:0] andi(logic [4:0] rd, logic [4:0] rs1, int imm);
    return i_type(imm[11:0], rs1, `F3_AND, rd);
  endfunction

  function automatic logic [31:0] ori(logic [4:0] rd, logic [4:0] rs1, int imm);
    return i_type(imm[11:0], rs1, `F3_OR, rd);
  endfunction

  function automatic logic [31:0] xori(logic [4:0] rd, logic [4:0] rs1, int imm);
    return i_type(imm[11:0], rs1, `F3_XOR, rd);
  endfunction

  function automatic logic [31:0] lui(logic [4:0] rd, int upper);
    return {upper[19:0], rd, `OPC_LUI};
  endfunction

  function automatic logic [31:0] add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return r_type(7'b0, rs2, rs1, `F3_ADD_SUB, rd);
  endfunction

  function automatic logic [31:0] sub(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return r_type(`F7_SUB, rs2, rs1, `F3_ADD_SUB, rd);
  endfunction

  function automatic logic [31:0] and_rr(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return r_type(7'b0, rs2, rs1, `F3_AND, rd);
  endfunction

  function automatic logic [31:0] or_rr(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return r_type(7'b0, rs2, rs1, `F3_OR, rd);
  endfunction

  function automatic logic [31:0] xor_rr(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return r_type(7'b0, rs2, rs1, `F3_XOR, rd);
  endfunction

  function automatic logic [31:0] beq(logic [4:0] rs1, logic [4:0] rs2, int off);
    return b_type(`F3_BEQ, rs1, rs2, off);
  endfunction

  function automatic logic [31:0] bne(logic [4:0] rs1, logic [4:0] rs2, int off);
    return b_type(`F3_BNE, rs1, rs2, off);
  endfunction

  function automatic logic [31:0] sw(logic [4:0] rs2, logic [4:0] rs1, int imm);
    logic [11:0] s;
    s = imm[11:0];
    return {s[11:5], rs2, rs1, `F3_SW, s[4:0], `OPC_STORE};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus models
  //////////////////////////////////////////////////////////////////////

  // Instruction memory, random grant and response delays
  initial begin
    logic [`XLEN-1:0] im_addr;
    logic [`XLEN-1:0] im_off;
    logic             im_busy;
    int               gnt_cnt;
    int               rsp_cnt;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    im_addr = '0;
    im_busy = 1'b0;
    gnt_cnt = 0;
    rsp_cnt = 0;
    forever begin
      @(negedge clk_i);
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      if (!rst_n_i) begin
        im_busy = 1'b0;
        gnt_cnt = 0;
      end else if (im_busy) begin
        if (rsp_cnt == 0) begin
          im_off         = im_addr - BOOT_ADDR;
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = imem[im_off[7:2]];
          im_busy        = 1'b0;
        end else begin
          rsp_cnt--;
        end
      end else if (instr_req_o) begin
        if (gnt_cnt == 0) begin
          instr_gnt_i = 1'b1;
          im_addr     = instr_addr_o;
          im_busy     = 1'b1;
          // Response at least one cycle after the grant
          rsp_cnt     = (max_dly == 0) ? 0 : $urandom_range(max_dly - 1, 0);
          gnt_cnt     = $urandom_range(max_dly, 0);
        end else begin
          gnt_cnt--;
        end
      end
    end
  end

  // Data memory, logs every granted store
  initial begin
    int dgnt_cnt;
    data_gnt_i = 1'b0;
    dgnt_cnt   = 0;
    forever begin
      @(negedge clk_i);
      data_gnt_i = 1'b0;
      if (!rst_n_i) begin
        // First store after reset waits first_st_dly cycles
        dgnt_cnt = first_st_dly;
      end else if (data_req_o) begin
        if (dgnt_cnt == 0) begin
          data_gnt_i = 1'b1;
          log_q.push_back(data_o);
          dgnt_cnt = $urandom_range(max_dly, 0);
        end else begin
          dgnt_cnt--;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_store(string name, store_req_t exp, store_req_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(string name, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Program and run helpers
  //////////////////////////////////////////////////////////////////////

  // Reset, then fill with no-ops keyed on the full address
  task automatic begin_program();
    logic [`XLEN-1:0] a;
    @(negedge clk_i);
    rst_n_i = 1'b0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      a = BOOT_ADDR + 32'(i * 4);
      imem[i[5:0]] = xori(5'd0, 5'd0, int'(a[11:0] ^ a[23:12] ^ {4'b0, a[31:24]}));
    end
    prog_len = 0;
    exp_q.delete();
  endtask

  task automatic emit(logic [31:0] word);
    imem[prog_len[5:0]] = word;
    prog_len++;
  endtask

  task automatic expect_store(logic [`XLEN-1:0] addr, logic [`XLEN-1:0] data);
    store_req_t s;
    s.addr  = addr;
    s.wdata = data;
    exp_q.push_back(s);
  endtask

  task automatic hold_reset();
    repeat (`TB_RST_CYCLES) begin
      @(negedge clk_i);
      if (instr_req_o || data_req_o) begin
        $display("Bus request raised while reset was asserted");
        errors++;
      end
    end
    log_q.delete();
    rst_n_i = 1'b1;
  endtask

  // Release reset, wait for all stores, then look for stray ones
  task automatic run_program(string name);
    hold_reset();
    while (log_q.size() < exp_q.size()) begin
      @(negedge clk_i);
    end
    repeat (TAIL_CYCLES) @(negedge clk_i);
    if (log_q.size() != exp_q.size()) begin
      $display("%s: expected %0d stores but saw %0d", name, exp_q.size(), log_q.size());
      errors++;
    end
    for (int i = 0; i < exp_q.size() && i < log_q.size(); i++) begin
      check_store($sformatf("%s data_o[%0d]", name, i), exp_q[i], log_q[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic boot_after_reset();
    int n;
    begin_program();
    emit(beq(5'd0, 5'd0, 0));
    hold_reset();
    n = 0;
    while (!instr_req_o && n < 8) begin
      @(negedge clk_i);
      n++;
    end
    if (!instr_req_o) begin
      $display("No instruction request after reset release");
      errors++;
    end else begin
      check_addr("instr_addr_o", BOOT_ADDR, instr_addr_o);
    end
  endtask

  task automatic alu_ops();
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] c;
    base = 32'h100;
    a    = 32'h5a3;
    b    = 32'(-300);
    c    = 32'hABCDE000;
    begin_program();
    emit(addi(5'd10, 5'd0, 32'h100));
    emit(addi(5'd1, 5'd0, 32'h5a3));
    emit(addi(5'd2, 5'd0, -300));
    emit(lui(5'd3, 32'hABCDE));
    emit(add(5'd4, 5'd1, 5'd2));
    emit(sw(5'd4, 5'd10, 0));
    emit(sub(5'd4, 5'd1, 5'd2));
    emit(sw(5'd4, 5'd10, 4));
    emit(and_rr(5'd4, 5'd3, 5'd2));
    emit(sw(5'd4, 5'd10, 8));
    emit(or_rr(5'd4, 5'd1, 5'd3));
    emit(sw(5'd4, 5'd10, 12));
    emit(xor_rr(5'd4, 5'd3, 5'd2));
    emit(sw(5'd4, 5'd10, 16));
    emit(andi(5'd4, 5'd3, -16));
    emit(sw(5'd4, 5'd10, 20));
    emit(ori(5'd4, 5'd1, 32'h70f));
    emit(sw(5'd4, 5'd10, 24));
    emit(xori(5'd4, 5'd2, -1));
    emit(sw(5'd4, 5'd10, 28));
    emit(addi(5'd4, 5'd3, 32'h7ff));
    // Negative S-immediate
    emit(sw(5'd4, 5'd10, -4));
    emit(sw(5'd3, 5'd10, 32));
    emit(beq(5'd0, 5'd0, 0));
    expect_store(base, a + b);
    expect_store(base + 32'd4, a - b);
    expect_store(base + 32'd8, c & b);
    expect_store(base + 32'd12, a | c);
    expect_store(base + 32'd16, c ^ b);
    expect_store(base + 32'd20, c & 32'hFFFF_FFF0);
    expect_store(base + 32'd24, a | 32'h70f);
    expect_store(base + 32'd28, ~b);
    expect_store(base - 32'd4, c + 32'h7ff);
    expect_store(base + 32'd32, c);
    run_program("alu");
  endtask

  task automatic dependency_chain();
    logic [`XLEN-1:0] v;
    v = 32'd7;
    v = v - 32'd3;
    v = v + v;
    v = v ^ 32'h55;
    v = 32'd0 - v;
    begin_program();
    emit(addi(5'd10, 5'd0, 32'h200));
    emit(addi(5'd5, 5'd0, 7));
    // Held store, the next three words pile up behind it
    emit(sw(5'd5, 5'd10, 12));
    emit(addi(5'd5, 5'd5, -3));
    emit(add(5'd5, 5'd5, 5'd5));
    emit(xori(5'd5, 5'd5, 32'h55));
    emit(sub(5'd5, 5'd0, 5'd5));
    emit(sw(5'd5, 5'd10, 0));
    // x0 write is dropped
    emit(addi(5'd0, 5'd5, 123));
    emit(sw(5'd0, 5'd10, 4));
    emit(add(5'd8, 5'd0, 5'd5));
    emit(sw(5'd8, 5'd10, 8));
    emit(beq(5'd0, 5'd0, 0));
    expect_store(32'h20c, 32'd7);
    expect_store(32'h200, v);
    expect_store(32'h204, 32'd0);
    expect_store(32'h208, v);
    first_st_dly = CHAIN_HOLD;
    run_program("chain");
    first_st_dly = 0;
  endtask

  task automatic branch_paths();
    begin_program();
    emit(addi(5'd10, 5'd0, 32'h300));
    emit(addi(5'd1, 5'd0, 5));
    emit(addi(5'd2, 5'd0, 5));
    emit(addi(5'd3, 5'd0, 9));
    emit(beq(5'd1, 5'd3, 8));
    emit(sw(5'd1, 5'd10, 0));
    emit(beq(5'd1, 5'd2, 8));
    // Shadow of a taken branch
    emit(sw(5'd3, 5'd10, 4));
    emit(sw(5'd3, 5'd10, 8));
    emit(bne(5'd1, 5'd3, 12));
    emit(sw(5'd1, 5'd10, 12));
    emit(sw(5'd2, 5'd10, 16));
    emit(sw(5'd2, 5'd10, 20));
    emit(bne(5'd1, 5'd2, 8));
    emit(sw(5'd3, 5'd10, 24));
    emit(beq(5'd0, 5'd0, 8));
    emit(sw(5'd1, 5'd10, 28));
    emit(beq(5'd0, 5'd0, 0));
    expect_store(32'h300, 32'd5);
    expect_store(32'h308, 32'd9);
    expect_store(32'h314, 32'd5);
    expect_store(32'h318, 32'd9);
    run_program("branch");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequencer and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(`TB_SEED));
    errors       = 0;
    rst_n_i      = 1'b0;
    boot_addr_i  = BOOT_ADDR;
    max_dly      = 0;
    first_st_dly = 0;
    prog_len     = 0;
    boot_after_reset();
    alu_ops();
    dependency_chain();
    branch_paths();
    // Same programs with a stalling memory
    max_dly = 3;
    alu_ops();
    dependency_chain();
    branch_paths();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(NUM_INSTR * 10 * `TB_CLK_PERIOD);
    $display("Watchdog expired before all stores were seen");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- verif/core_props.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module core_props (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 instr_req_o,
  input logic [`XLEN-1:0]     instr_addr_o,
  input logic                 instr_gnt_i,
  input logic                 data_req_o,
  input core_pkg::store_req_t data_o,
  input logic                 data_gnt_i
);

  // Fetch request and address held until granted
  a_instr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instr_addr_o moved before instr_gnt_i");

  // Store payload frozen until granted
  a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_o))
    else $error("data_o moved before data_gnt_i");

  // Quiet buses in reset
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !instr_req_o && !data_req_o)
    else $error("bus request raised during reset");

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module core_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [`XLEN-1:0]     boot_addr_i,
  // Instruction bus
  output logic                 instr_req_o,
  output logic [`XLEN-1:0]     instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  logic [31:0]          instr_rdata_i,
  // Data bus, stores only
  output logic                 data_req_o,
  output core_pkg::store_req_t data_o,
  input  logic                 data_gnt_i
);

  import core_pkg::*;

  if_id_t                 if_id;
  id_ex_t                 id_ex;
  rf_wr_t                 rf_wr;
  redirect_t              redirect;
  logic                   id_ready;
  logic                   ex_ready;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  //////////////////////////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////////////////////////

  if_stage i_if_stage (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .id_ready_i     ( id_ready       ),
    .redirect_i     ( redirect       ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .if_id_o        ( if_id          )
  );

  //////////////////////////////////////////////////////////////////////
  // Decode and register read
  //////////////////////////////////////////////////////////////////////

  id_stage i_id_stage (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .if_id_i    ( if_id    ),
    .ex_ready_i ( ex_ready ),
    .redirect_i ( redirect ),
    .rs1_data_i ( rs1_data ),
    .rs2_data_i ( rs2_data ),
    .rs1_addr_o ( rs1_addr ),
    .rs2_addr_o ( rs2_addr ),
    .id_ready_o ( id_ready ),
    .id_ex_o    ( id_ex    )
  );

  register_file i_register_file (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .rs1_addr_i ( rs1_addr ),
    .rs2_addr_i ( rs2_addr ),
    .rf_wr_i    ( rf_wr    ),
    .rs1_data_o ( rs1_data ),
    .rs2_data_o ( rs2_data )
  );

  //////////////////////////////////////////////////////////////////////
  // Execute, branch and store
  //////////////////////////////////////////////////////////////////////

  ex_stage i_ex_stage (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .id_ex_i    ( id_ex      ),
    .data_gnt_i ( data_gnt_i ),
    .ex_ready_o ( ex_ready   ),
    .redirect_o ( redirect   ),
    .rf_wr_o    ( rf_wr      ),
    .data_req_o ( data_req_o ),
    .data_o     ( data_o     )
  );

endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module ex_stage (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  core_pkg::id_ex_t     id_ex_i,
  input  logic                 data_gnt_i,
  output logic                 ex_ready_o,
  output core_pkg::redirect_t  redirect_o,
  output core_pkg::rf_wr_t     rf_wr_o,
  output logic                 data_req_o,
  output core_pkg::store_req_t data_o
);

  import core_pkg::*;

  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] br_target;
  logic             ops_equal;
  logic             ex_fire;
  logic             st_load;
  logic             st_valid_q;
  store_req_t       st_q;

  //////////////////////////////////////////////////////////////////////
  // ALU and branch compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_SUB:    alu_res = id_ex_i.op_a - id_ex_i.op_b;
      ALU_AND:    alu_res = id_ex_i.op_a & id_ex_i.op_b;
      ALU_OR:     alu_res = id_ex_i.op_a | id_ex_i.op_b;
      ALU_XOR:    alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
      ALU_PASS_B: alu_res = id_ex_i.op_b;
      // add, also store address
      default:    alu_res = id_ex_i.op_a + id_ex_i.op_b;
    endcase
  end

  assign ops_equal = (id_ex_i.op_a == id_ex_i.op_b);
  assign br_target = id_ex_i.pc + {{(`XLEN-13){id_ex_i.br_off[12]}}, id_ex_i.br_off};

  // Stall only while the store buffer waits on its grant
  assign ex_ready_o = !st_valid_q || data_gnt_i;
  assign ex_fire    = id_ex_i.valid && ex_ready_o;

  // Redirect strobe, one cycle per taken branch
  assign redirect_o.flush  = ex_fire &&
                             ((id_ex_i.br_eq && ops_equal) || (id_ex_i.br_ne && !ops_equal));
  assign redirect_o.target = br_target;

  // Writeback happens on the EX cycle
  assign rf_wr_o.we   = ex_fire && id_ex_i.rd_we;
  assign rf_wr_o.addr = id_ex_i.rd;
  assign rf_wr_o.data = alu_res;

  //////////////////////////////////////////////////////////////////////
  // Store request register
  //////////////////////////////////////////////////////////////////////

  assign st_load = ex_fire && id_ex_i.store;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      st_valid_q <= 1'b0;
    end else if (st_load) begin
      st_valid_q <= 1'b1;
    end else if (data_gnt_i) begin
      st_valid_q <= 1'b0;
    end
  end

  // Payload frozen until granted
  always_ff @(posedge clk_i) begin
    if (st_load) begin
      st_q.addr  <= alu_res;
      st_q.wdata <= id_ex_i.st_data;
    end
  end

  assign data_req_o = st_valid_q;
  assign data_o     = st_q;

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module register_file (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
  input  core_pkg::rf_wr_t       rf_wr_i,
  output logic [`XLEN-1:0]       rs1_data_o,
  output logic [`XLEN-1:0]       rs2_data_o
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic             rs1_hit;
  logic             rs2_hit;

  // Entry 0 only ever sees the reset value
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_wr_i.we && rf_wr_i.addr != '0) begin
      regs[rf_wr_i.addr] <= rf_wr_i.data;
    end
  end

  // Write-through bypass for the same-cycle EX write
  assign rs1_hit = rf_wr_i.we && (rf_wr_i.addr == rs1_addr_i) && (rs1_addr_i != '0);
  assign rs2_hit = rf_wr_i.we && (rf_wr_i.addr == rs2_addr_i) && (rs2_addr_i != '0);

  assign rs1_data_o = rs1_hit ? rf_wr_i.data : regs[rs1_addr_i];
  assign rs2_data_o = rs2_hit ? rf_wr_i.data : regs[rs2_addr_i];

endmodule

//--- verilog/id_stage.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module id_stage (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  core_pkg::if_id_t       if_id_i,
  input  logic                   ex_ready_i,
  input  core_pkg::redirect_t    redirect_i,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  output logic [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`REG_ADDR_W-1:0] rs2_addr_o,
  output logic                   id_ready_o,
  output core_pkg::id_ex_t       id_ex_o
);

  import core_pkg::*;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_u;
  logic [12:0]      imm_b;
  logic             known;
  id_ex_t           dec;
  id_ex_t           id_ex_q;

  // Instruction fields
  assign opcode = if_id_i.instr[6:0];
  assign funct3 = if_id_i.instr[14:12];
  assign funct7 = if_id_i.instr[31:25];

  // Register read addresses straight from the word
  assign rs1_addr_o = if_id_i.instr[19:15];
  assign rs2_addr_o = if_id_i.instr[24:20];

  // Immediates
  assign imm_i = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
  assign imm_s = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:25], if_id_i.instr[11:7]};
  assign imm_u = {if_id_i.instr[31:12], 12'b0};
  assign imm_b = {if_id_i.instr[31], if_id_i.instr[7], if_id_i.instr[30:25],
                  if_id_i.instr[11:8], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dec         = '0;
    known       = 1'b0;
    dec.pc      = if_id_i.pc;
    dec.op_a    = rs1_data_i;
    dec.op_b    = rs2_data_i;
    dec.st_data = rs2_data_i;
    dec.rd      = if_id_i.instr[11:7];
    dec.br_off  = imm_b;

    case (opcode)
      `OPC_OP_IMM: begin
        dec.op_b  = imm_i;
        dec.rd_we = 1'b1;
        known     = 1'b1;
        case (funct3)
          `F3_ADD_SUB: dec.alu_op = ALU_ADD;
          `F3_XOR:     dec.alu_op = ALU_XOR;
          `F3_OR:      dec.alu_op = ALU_OR;
          `F3_AND:     dec.alu_op = ALU_AND;
          // shifts and compares are outside the subset
          default:     known = 1'b0;
        endcase
      end
      `OPC_OP: begin
        dec.rd_we = 1'b1;
        known     = (funct7 == 7'b0) || (funct7 == `F7_SUB && funct3 == `F3_ADD_SUB);
        case (funct3)
          `F3_ADD_SUB: dec.alu_op = (funct7 == `F7_SUB) ? ALU_SUB : ALU_ADD;
          `F3_XOR:     dec.alu_op = ALU_XOR;
          `F3_OR:      dec.alu_op = ALU_OR;
          `F3_AND:     dec.alu_op = ALU_AND;
          default:     known = 1'b0;
        endcase
      end
      `OPC_LUI: begin
        dec.op_b   = imm_u;
        dec.alu_op = ALU_PASS_B;
        dec.rd_we  = 1'b1;
        known      = 1'b1;
      end
      `OPC_BRANCH: begin
        known = 1'b1;
        case (funct3)
          `F3_BEQ: dec.br_eq = 1'b1;
          `F3_BNE: dec.br_ne = 1'b1;
          default: known = 1'b0;
        endcase
      end
      `OPC_STORE: begin
        // Address is rs1 plus S-imm through the adder
        dec.op_b  = imm_s;
        dec.store = 1'b1;
        known     = (funct3 == `F3_SW);
      end
      default: known = 1'b0;
    endcase

    // Unsupported words turn into bubbles
    if (!known) begin
      dec.rd_we = 1'b0;
    end
    dec.valid = if_id_i.valid && known;
  end

  assign id_ready_o = !id_ex_q.valid || ex_ready_i;

  // ID/EX register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_q <= '0;
    end else if (redirect_i.flush) begin
      id_ex_q.valid <= 1'b0;
    end else if (id_ready_o) begin
      id_ex_q <= dec;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

//--- verilog/if_stage.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module if_stage (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [`XLEN-1:0]    boot_addr_i,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [31:0]         instr_rdata_i,
  input  logic                id_ready_i,
  input  core_pkg::redirect_t redirect_i,
  output logic                instr_req_o,
  output logic [`XLEN-1:0]    instr_addr_o,
  output core_pkg::if_id_t    if_id_o
);

  import core_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT
  } fetch_state_e;

  fetch_state_e     state_q;
  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] fetch_pc;
  logic             discard_q;
  logic             resp_ok;
  logic             slot_free;
  if_id_t           resp;
  if_id_t           if_id_q;
  if_id_t           skid_q;

  // Redirect target wins over the sequential PC
  assign fetch_pc = redirect_i.flush ? redirect_i.target : pc_q;

  assign instr_req_o  = (state_q == S_REQ);
  assign instr_addr_o = addr_q;

  //////////////////////////////////////////////////////////////////////
  // Fetch FSM, one request outstanding
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      pc_q      <= boot_addr_i;
      addr_q    <= '0;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // Hold off while the skid entry is occupied
          if (!skid_q.valid || redirect_i.flush) begin
            state_q <= S_REQ;
            addr_q  <= fetch_pc;
            pc_q    <= fetch_pc + `XLEN'd4;
          end
        end
        S_REQ: begin
          // Address stays put until granted
          if (instr_gnt_i) begin
            state_q <= S_WAIT;
          end
          if (redirect_i.flush) begin
            pc_q      <= redirect_i.target;
            discard_q <= 1'b1;
          end
        end
        default: begin
          if (instr_rvalid_i) begin
            state_q   <= S_IDLE;
            discard_q <= 1'b0;
          end else if (redirect_i.flush) begin
            discard_q <= 1'b1;
          end
          if (redirect_i.flush) begin
            pc_q <= redirect_i.target;
          end
        end
      endcase
    end
  end

  // Response tagged with the address it came from
  assign resp      = '{valid: 1'b1, pc: addr_q, instr: instr_rdata_i};
  assign resp_ok   = (state_q == S_WAIT) && instr_rvalid_i && !discard_q && !redirect_i.flush;
  assign slot_free = !if_id_q.valid || id_ready_i;

  // IF/ID register plus one skid entry
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_q <= '0;
      skid_q  <= '0;
    end else if (redirect_i.flush) begin
      if_id_q.valid <= 1'b0;
      skid_q.valid  <= 1'b0;
    end else if (slot_free) begin
      if (skid_q.valid) begin
        if_id_q      <= skid_q;
        skid_q.valid <= 1'b0;
      end else if (resp_ok) begin
        if_id_q <= resp;
      end else begin
        if_id_q.valid <= 1'b0;
      end
    end else if (resp_ok) begin
      // ID stalled, park the word
      skid_q <= resp;
    end
  end

  assign if_id_o = if_id_q;

endmodule

//--- verilog/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

  // ALU operation select
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_e;

  // IF/ID pipeline register
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [31:0]      instr;
  } if_id_t;

  // ID/EX pipeline register
  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;
    logic [`XLEN-1:0]       st_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_we;
    alu_op_e                alu_op;
    logic                   br_eq;
    logic                   br_ne;
    logic                   store;
    // B-immediate, bit 0 always zero
    logic [12:0]            br_off;
  } id_ex_t;

  // Register file write port
  typedef struct packed {
    logic                   we;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`XLEN-1:0]       data;
  } rf_wr_t;

  // Taken branch redirect from EX
  typedef struct packed {
    logic             flush;
    logic [`XLEN-1:0] target;
  } redirect_t;

  // Data bus store request payload
  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } store_req_t;

endpackage

//--- include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and register file geometry
`define XLEN        32
`define NUM_REGS    32
`define REG_ADDR_W  5

// Major opcodes of the kept subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011
`define OPC_STORE   7'b0100011

// funct3 codes
`define F3_ADD_SUB  3'b000
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_SW       3'b010

// funct7 of SUB
`define F7_SUB      7'b0100000

`endif
